/* vlog.f */
python_rx_pkg.sv
python_2bit_to_10bit.sv
python_sync_decoder.sv
python_rx_regs.sv
python_rx_top.sv
tb_python_rx.sv

/* Bender.yml */
package:
  name: python_rx

sources:
  - python_rx_pkg.sv
  - python_2bit_to_10bit.sv
  - python_sync_decoder.sv
  - python_rx_regs.sv
  - python_rx_top.sv
  - target: test
    files:
      - tb_python_rx.sv

/* tb_python_rx.sv */
`default_nettype none

module tb_python_rx;

    localparam int unsigned NL         = python_rx_pkg::NUM_LANES;
    localparam logic [9:0]  TRAIN      = 10'h3a6;
    localparam logic [1:0]  OKAY       = 2'd0;
    localparam logic [1:0]  SLVERR     = 2'd2;
    localparam logic [7:0]  A_CTRL     = 8'(python_rx_pkg::REG_CTRL);
    localparam logic [7:0]  A_PATTERN  = 8'(python_rx_pkg::REG_PATTERN);
    localparam logic [7:0]  A_STATUS   = 8'(python_rx_pkg::REG_STATUS);
    localparam logic [7:0]  A_FRAMES   = 8'(python_rx_pkg::REG_FRAMES);
    localparam logic [7:0]  A_LINES    = 8'(python_rx_pkg::REG_LINES);
    localparam logic [7:0]  A_UNMAPPED = 8'h20;

    // four calibrations, one burst, one test frame and three counted frames.
    localparam int unsigned WORDS_SENT = 4 * 4 + 8 + 12 + 38;
    localparam int unsigned AXI_OPS    = 27;
    localparam int unsigned WATCHDOG   = (WORDS_SENT * 5 + AXI_OPS * 4) * 2 + 16;

    logic                       clk;
    logic                       rst_n;
    logic [NL-1:0][1:0]         s_data;
    logic [1:0]                 s_sync;
    logic                       s_valid;
    logic [7:0]                 awaddr;
    logic [7:0]                 araddr;
    logic [31:0]                wdata;
    logic [3:0]                 wstrb;
    logic                       awvalid;
    logic                       wvalid;
    logic                       bready;
    logic                       arvalid;
    logic                       rready;
    logic                       awready;
    logic                       wready;
    logic                       bvalid;
    logic                       arready;
    logic                       rvalid;
    logic [1:0]                 bresp;
    logic [1:0]                 rresp;
    logic [31:0]                rdata;
    python_rx_pkg::pixel_beat_t pixel;
    logic                       pixel_valid;
    logic                       calib_done;
    logic                       calib_error;

    python_rx_pkg::pixel_beat_t exp_q[$];
    python_rx_pkg::pixel_beat_t exp_head = '0;
    int unsigned                exp_count = 0;
    int unsigned                errors = 0;
    int unsigned                beats = 0;
    logic [15:0]                lfsr = 16'd36;
    logic [9:0]                 shadow;

    python_rx_top #(.ADDR_WIDTH(8)) python_rx_top_inst (
        .clk(clk), .rst_n(rst_n), .s_data(s_data), .s_sync(s_sync), .s_valid(s_valid),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready), .wdata(wdata),
        .wstrb(wstrb), .wvalid(wvalid), .wready(wready), .bresp(bresp),
        .bvalid(bvalid), .bready(bready), .araddr(araddr), .arvalid(arvalid),
        .arready(arready), .rdata(rdata), .rresp(rresp), .rvalid(rvalid),
        .rready(rready), .pixel(pixel), .pixel_valid(pixel_valid),
        .calib_done(calib_done), .calib_error(calib_error)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] random_bits(input int unsigned n);
        logic [15:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr  = {lfsr[14:0], fb};
            value = {value[14:0], fb};
        end
        return value;
    endfunction

    function automatic logic [NL-1:0][9:0] random_data();
        logic [NL-1:0][9:0] data;
        for (int l = 0; l < NL; l++) begin
            data[l] = 10'(random_bits(10));
        end
        return data;
    endfunction

    // a marker in the low seven bits names an event, anything else is a data type.
    function automatic python_rx_pkg::pixel_beat_t expected_beat(
        input logic [NL-1:0][9:0] data, input logic [9:0] sync);
        python_rx_pkg::pixel_beat_t beat;
        beat      = '0;
        beat.data = data;
        if (sync[6:0] == python_rx_pkg::SYNC_MARKER) begin
            beat.frame_start = (sync[9:7] == python_rx_pkg::CODE_FS);
            beat.line_start  = (sync[9:7] == python_rx_pkg::CODE_LS);
            beat.line_end    = (sync[9:7] == python_rx_pkg::CODE_LE);
            beat.frame_end   = (sync[9:7] == python_rx_pkg::CODE_FE);
        end else begin
            beat.image = (sync == python_rx_pkg::SYNC_IMAGE);
            beat.black = (sync == python_rx_pkg::SYNC_BLACK);
        end
        return beat;
    endfunction

    function automatic void refresh_head();
        exp_count = exp_q.size();
        if (exp_count != 0) begin
            exp_head = exp_q[0];
        end
    endfunction

    always @(posedge clk) begin
        if (pixel_valid && exp_q.size() != 0) begin
            exp_q.delete(0);
            beats++;
            refresh_head();
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) pixel_valid |-> calib_done)
        else begin
            errors++;
            $display("pixel_valid was raised while the gearbox was not calibrated");
        end

    assert property (@(posedge clk) disable iff (!rst_n) pixel_valid |-> exp_count != 0)
        else begin
            errors++;
            $display("a pixel beat arrived when none was expected");
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        (pixel_valid && exp_count != 0) |-> pixel == exp_head)
        else begin
            errors++;
            $display("Error pixel: got %h expected %h", $sampled(pixel), $sampled(exp_head));
        end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [1:0] resp,
                             input bit aw_lead = 1'b0);
        int unsigned n;
        n       = 0;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        if (aw_lead) begin
            @(negedge clk); // address waits a cycle for its data.
        end
        wvalid = 1'b1;
        do begin
            @(posedge clk);
            n++;
        end while (!(awready && wready) && n < 16);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        assert (bvalid && n < 16) else begin
            errors++;
            $display("write to address %h was not answered", addr);
        end
        check_value("bresp", 32'(bresp), 32'(resp));
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic [31:0] exp,
                            input logic [1:0] resp);
        int unsigned n;
        n       = 0;
        araddr  = addr;
        arvalid = 1'b1;
        do begin
            @(posedge clk);
            n++;
        end while (!arready && n < 16);
        @(negedge clk);
        arvalid = 1'b0;
        assert (rvalid && n < 16) else begin
            errors++;
            $display("read of address %h was not answered", addr);
        end
        check_value($sformatf("rdata@%02h", addr), rdata, exp);
        check_value("rresp", 32'(rresp), 32'(resp));
        if (addr == A_STATUS) begin
            check_value("{calib_error, calib_done}", 32'({calib_error, calib_done}), exp);
        end
    endtask

    task automatic send_slice(input logic [NL-1:0][1:0] data, input logic [1:0] sync);
        s_data  = data;
        s_sync  = sync;
        s_valid = 1'b1;
        @(negedge clk);
        s_valid = 1'b0;
    endtask

    task automatic send_word(input logic [NL-1:0][9:0] data, input logic [9:0] sync,
                             input bit expect_beat);
        logic [NL-1:0][1:0] slice;
        if (expect_beat) begin
            exp_q.push_back(expected_beat(data, sync));
            refresh_head();
        end
        for (int s = 4; s >= 0; s--) begin
            for (int l = 0; l < NL; l++) begin
                slice[l] = data[l][2*s +: 2];
            end
            send_slice(slice, sync[2*s +: 2]); // msb slice first.
        end
        if (random_bits(1) == 16'd1) begin
            @(negedge clk);
        end
    endtask

    task automatic send_sync(input logic [2:0] code);
        send_word(random_data(), {code, python_rx_pkg::SYNC_MARKER}, 1'b1);
    endtask

    task automatic send_frame(input int unsigned lines);
        send_sync(python_rx_pkg::CODE_FS);
        repeat (lines) begin
            send_sync(python_rx_pkg::CODE_LS);
            repeat (2) send_word(random_data(), python_rx_pkg::SYNC_IMAGE, 1'b1);
            send_sync(python_rx_pkg::CODE_LE);
        end
        send_sync(python_rx_pkg::CODE_FE);
    endtask

    task automatic calibrate(input bit bad_lane);
        logic [NL-1:0][9:0] train;
        int unsigned        pad;
        train = {NL{TRAIN}};
        write_reg(A_CTRL, 32'd1, 4'h1, OKAY);
        repeat (5) send_slice('0, '0);          // clears the old window.
        write_reg(A_CTRL, 32'd0, 4'h1, OKAY);
        pad = int'(random_bits(3)) % 5;
        repeat (pad) send_slice('0, '0);
        if (bad_lane) begin
            train[2] = ~TRAIN;
        end
        send_word(train, TRAIN, 1'b0);
        send_word({NL{TRAIN}}, TRAIN, !bad_lane); // first word after lock.
    endtask

    task automatic wait_drain();
        int unsigned n;
        n = 0;
        while (exp_q.size() != 0 && n < 32) begin
            @(negedge clk);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected pixel beats never arrived", exp_q.size());
        end
    endtask

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired after %0d cycles", WATCHDOG);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst_n   = 1'b0;
        s_data  = '0;
        s_sync  = '0;
        s_valid = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        write_reg(A_PATTERN, 32'(TRAIN), 4'h3, OKAY);
        calibrate(1'b0);
        wait_drain();
        read_reg(A_STATUS, 32'h1, OKAY);

        calibrate(1'b1);
        read_reg(A_STATUS, 32'h2, OKAY);
        calibrate(1'b0);
        wait_drain();
        read_reg(A_STATUS, 32'h1, OKAY);

        repeat (8) send_word(random_data(), python_rx_pkg::SYNC_IMAGE, 1'b1);
        wait_drain();

        send_sync(python_rx_pkg::CODE_FS);
        send_sync(python_rx_pkg::CODE_LS);
        repeat (3) send_word(random_data(), python_rx_pkg::SYNC_IMAGE, 1'b1);
        send_sync(python_rx_pkg::CODE_LE);
        send_sync(python_rx_pkg::CODE_LS);
        repeat (2) send_word(random_data(), python_rx_pkg::SYNC_BLACK, 1'b1);
        send_sync(python_rx_pkg::CODE_LE);
        send_sync(3'd3);                        // marker with an unused code.
        send_sync(python_rx_pkg::CODE_FE);
        wait_drain();
        read_reg(A_FRAMES, 32'd1, OKAY);
        read_reg(A_LINES, 32'd2, OKAY);

        calibrate(1'b0);                        // also clears the counters.
        send_frame(3);
        send_frame(1);
        send_frame(4);
        wait_drain();
        read_reg(A_FRAMES, 32'd3, OKAY);
        read_reg(A_LINES, 32'd4, OKAY);

        shadow = TRAIN;
        write_reg(A_PATTERN, 32'h0000_0155, 4'h1, OKAY);
        shadow[7:0] = 8'h55;
        read_reg(A_PATTERN, 32'(shadow), OKAY);
        write_reg(A_PATTERN, 32'hffff_fe00, 4'h2, OKAY, 1'b1);
        shadow[9:8] = 2'b10;
        read_reg(A_PATTERN, 32'(shadow), OKAY);
        write_reg(A_PATTERN, 32'hffff_ffff, 4'hc, OKAY);
        read_reg(A_PATTERN, 32'(shadow), OKAY);
        read_reg(A_UNMAPPED, 32'd0, SLVERR);
        write_reg(A_UNMAPPED, 32'hffff_ffff, 4'hf, SLVERR);
        write_reg(A_STATUS, 32'hffff_ffff, 4'hf, OKAY);
        read_reg(A_STATUS, 32'h1, OKAY);
        read_reg(A_CTRL, 32'd0, OKAY);

        $display("errors: %0d, pixel beats checked: %0d, beats pending: %0d",
                 errors, beats, exp_q.size());
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* python_rx_top.sv */
`default_nettype none

module python_rx_top #(
    parameter int unsigned ADDR_WIDTH = 8
) (
    input  var logic                                clk,
    input  var logic                                rst_n,

    input  var logic [python_rx_pkg::NUM_LANES-1:0][python_rx_pkg::SLICE_BITS-1:0] s_data,
    input  var logic [python_rx_pkg::SLICE_BITS-1:0] s_sync,
    input  var logic                                s_valid,

    input  var logic [ADDR_WIDTH-1:0]               awaddr,
    input  var logic                                awvalid,
    output var logic                                awready,
    input  var logic [31:0]                         wdata,
    input  var logic [3:0]                          wstrb,
    input  var logic                                wvalid,
    output var logic                                wready,
    output var logic [1:0]                          bresp,
    output var logic                                bvalid,
    input  var logic                                bready,
    input  var logic [ADDR_WIDTH-1:0]               araddr,
    input  var logic                                arvalid,
    output var logic                                arready,
    output var logic [31:0]                         rdata,
    output var logic [1:0]                          rresp,
    output var logic                                rvalid,
    input  var logic                                rready,

    output var python_rx_pkg::pixel_beat_t          pixel,
    output var logic                                pixel_valid,
    output var logic                                calib_done,
    output var logic                                calib_error
);

    python_rx_pkg::lane_word_t              word;
    logic                                   word_valid;
    logic                                   sw_reset;
    logic [python_rx_pkg::WORD_BITS-1:0]    pattern;
    logic [31:0]                            frame_count;
    logic [15:0]                            line_count;

    python_2bit_to_10bit python_2bit_to_10bit_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .sw_reset    (sw_reset),
        .pattern     (pattern),
        .calib_done  (calib_done),
        .calib_error (calib_error),
        .s_data      (s_data),
        .s_sync      (s_sync),
        .s_valid     (s_valid),
        .word        (word),
        .word_valid  (word_valid)
    );

    python_sync_decoder python_sync_decoder_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .sw_reset    (sw_reset),
        .word        (word),
        .word_valid  (word_valid),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .frame_count (frame_count),
        .line_count  (line_count)
    );

    python_rx_regs #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) python_rx_regs_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .sw_reset    (sw_reset),
        .pattern     (pattern),
        .calib_done  (calib_done),
        .calib_error (calib_error),
        .frame_count (frame_count),
        .line_count  (line_count)
    );

endmodule

`default_nettype wire

/* python_rx_regs.sv */
`default_nettype none

module python_rx_regs #(
    parameter int unsigned ADDR_WIDTH = 8
) (
    input  var logic                                clk,
    input  var logic                                rst_n,

    input  var logic [ADDR_WIDTH-1:0]               awaddr,
    input  var logic                                awvalid,
    output var logic                                awready,
    input  var logic [31:0]                         wdata,
    input  var logic [3:0]                          wstrb,
    input  var logic                                wvalid,
    output var logic                                wready,
    output var logic [1:0]                          bresp,
    output var logic                                bvalid,
    input  var logic                                bready,
    input  var logic [ADDR_WIDTH-1:0]               araddr,
    input  var logic                                arvalid,
    output var logic                                arready,
    output var logic [31:0]                         rdata,
    output var logic [1:0]                          rresp,
    output var logic                                rvalid,
    input  var logic                                rready,

    output var logic                                sw_reset,
    output var logic [python_rx_pkg::WORD_BITS-1:0] pattern,
    input  var logic                                calib_done,
    input  var logic                                calib_error,
    input  var logic [31:0]                         frame_count,
    input  var logic [15:0]                         line_count
);

    localparam logic [ADDR_WIDTH-1:0] A_CTRL    = ADDR_WIDTH'(python_rx_pkg::REG_CTRL);
    localparam logic [ADDR_WIDTH-1:0] A_PATTERN = ADDR_WIDTH'(python_rx_pkg::REG_PATTERN);
    localparam logic [ADDR_WIDTH-1:0] A_STATUS  = ADDR_WIDTH'(python_rx_pkg::REG_STATUS);
    localparam logic [ADDR_WIDTH-1:0] A_FRAMES  = ADDR_WIDTH'(python_rx_pkg::REG_FRAMES);
    localparam logic [ADDR_WIDTH-1:0] A_LINES   = ADDR_WIDTH'(python_rx_pkg::REG_LINES);

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    logic        wr_fire;
    logic        rd_fire;
    logic        wr_mapped;
    logic        rd_mapped;
    logic [31:0] rd_data;

    function automatic logic is_mapped(input logic [ADDR_WIDTH-1:0] addr);
        return (addr == A_CTRL) || (addr == A_PATTERN) || (addr == A_STATUS) ||
               (addr == A_FRAMES) || (addr == A_LINES);
    endfunction

    // both halves of a write are taken together, never while b is pending.
    assign wr_fire   = awvalid && wvalid && !bvalid;
    assign awready   = wr_fire;
    assign wready    = wr_fire;
    assign rd_fire   = arvalid && !rvalid;
    assign arready   = rd_fire;
    assign wr_mapped = is_mapped(awaddr);
    assign rd_mapped = is_mapped(araddr);

    always_comb begin
        case (araddr)
            A_CTRL:    rd_data = {31'd0, sw_reset};
            A_PATTERN: rd_data = {{(32 - python_rx_pkg::WORD_BITS){1'b0}}, pattern};
            A_STATUS:  rd_data = {30'd0, calib_error, calib_done};
            A_FRAMES:  rd_data = frame_count;
            A_LINES:   rd_data = {16'd0, line_count};
            default:   rd_data = '0;           // unmapped reads as zero.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sw_reset <= 1'b0;
            pattern  <= python_rx_pkg::PATTERN_RESET;
        end else if (wr_fire) begin
            if (awaddr == A_CTRL && wstrb[0]) begin
                sw_reset <= wdata[0];
            end
            if (awaddr == A_PATTERN) begin
                if (wstrb[0]) begin
                    pattern[7:0] <= wdata[7:0];
                end
                if (wstrb[1]) begin
                    pattern[9:8] <= wdata[9:8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            bresp  <= RESP_OKAY;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
            bresp  <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            rresp  <= RESP_OKAY;
            rdata  <= '0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
            rresp  <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
            rdata  <= rd_data;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* python_sync_decoder.sv */
`default_nettype none

module python_sync_decoder (
    input  var logic                        clk,
    input  var logic                        rst_n,
    input  var logic                        sw_reset,
    input  var python_rx_pkg::lane_word_t   word,
    input  var logic                        word_valid,
    output var python_rx_pkg::pixel_beat_t  pixel,
    output var logic                        pixel_valid,
    output var logic [31:0]                 frame_count,
    output var logic [15:0]                 line_count
);

    python_rx_pkg::sync_word_u  sync;
    python_rx_pkg::pixel_beat_t beat_next;
    logic [15:0]                line_acc;

    always_comb begin
        sync           = word.sync;
        beat_next      = '0;
        beat_next.data = word.data;
        if (sync.fields.marker == python_rx_pkg::SYNC_MARKER) begin
            case (sync.fields.code)
                python_rx_pkg::CODE_FS: begin
                    beat_next.frame_start = 1'b1;
                end
                python_rx_pkg::CODE_LS: begin
                    beat_next.line_start = 1'b1;
                end
                python_rx_pkg::CODE_LE: begin
                    beat_next.line_end = 1'b1;
                end
                python_rx_pkg::CODE_FE: begin
                    beat_next.frame_end = 1'b1;
                end
                default: begin
                    beat_next.image = 1'b0; // unknown code carries no event.
                end
            endcase
        end else begin
            // not a frame/line sync, so the whole word is the data type.
            beat_next.image = (sync.raw == python_rx_pkg::SYNC_IMAGE);
            beat_next.black = (sync.raw == python_rx_pkg::SYNC_BLACK);
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid) begin
            pixel <= beat_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_valid <= 1'b0;
            line_acc    <= '0;
            line_count  <= '0;
            frame_count <= '0;
        end else if (sw_reset) begin
            pixel_valid <= 1'b0;
            line_acc    <= '0;
            line_count  <= '0;
            frame_count <= '0;
        end else begin
            pixel_valid <= word_valid;
            if (word_valid) begin
                if (beat_next.frame_start) begin
                    line_acc <= '0;
                end
                if (beat_next.line_start) begin
                    line_acc <= line_acc + 1'b1;
                end
                if (beat_next.frame_end) begin
                    line_count  <= line_acc;          // lines of the frame just closed.
                    line_acc    <= '0;
                    frame_count <= frame_count + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* python_2bit_to_10bit.sv */
`default_nettype none

module python_2bit_to_10bit (
    input  var logic                                    clk,
    input  var logic                                    rst_n,
    input  var logic                                    sw_reset,
    input  var logic [python_rx_pkg::WORD_BITS-1:0]     pattern,
    output var logic                                    calib_done,
    output var logic                                    calib_error,
    input  var logic [python_rx_pkg::NUM_LANES-1:0][python_rx_pkg::SLICE_BITS-1:0] s_data,
    input  var logic [python_rx_pkg::SLICE_BITS-1:0]    s_sync,
    input  var logic                                    s_valid,
    output var python_rx_pkg::lane_word_t               word,
    output var logic                                    word_valid
);

    localparam int unsigned NL = python_rx_pkg::NUM_LANES;
    localparam int unsigned WB = python_rx_pkg::WORD_BITS;
    localparam int unsigned SB = python_rx_pkg::SLICE_BITS;
    localparam int unsigned PHASE_BITS = $clog2(python_rx_pkg::SLICES_PER_WORD);
    localparam logic [PHASE_BITS-1:0] PHASE_LAST =
        PHASE_BITS'(python_rx_pkg::SLICES_PER_WORD - 1);

    logic [NL-1:0][WB-1:0]  shift_data;
    logic [NL-1:0][WB-1:0]  next_data;
    logic [WB-1:0]          shift_sync;
    logic [WB-1:0]          next_sync;
    logic [PHASE_BITS-1:0]  phase;
    logic                   detect;
    logic                   lane_mismatch;

    // window including the slice arriving now.
    always_comb begin
        for (int i = 0; i < NL; i++) begin
            next_data[i] = {shift_data[i][WB-SB-1:0], s_data[i]};
        end
        next_sync = {shift_sync[WB-SB-1:0], s_sync};
    end

    // all lanes carry the same training word, lane 3 included.
    always_comb begin
        lane_mismatch = 1'b0;
        for (int i = 1; i < NL; i++) begin
            if (s_data[i] != s_data[0]) begin
                lane_mismatch = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_valid) begin
            shift_data <= next_data;
            shift_sync <= next_sync;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= '0;
            detect      <= 1'b0;
            calib_done  <= 1'b0;
            calib_error <= 1'b0;
            word_valid  <= 1'b0;
        end else if (sw_reset) begin
            phase       <= '0;
            detect      <= 1'b0;
            calib_done  <= 1'b0;
            calib_error <= 1'b0;
            word_valid  <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (s_valid) begin
                detect <= (next_data[0] == pattern); // registered match.

                if (phase >= PHASE_LAST) begin
                    phase      <= '0;
                    word_valid <= calib_done;        // words only once locked.
                end else begin
                    phase <= phase + 1'b1;
                end

                if (!calib_done) begin
                    if (lane_mismatch) begin
                        calib_error <= 1'b1;
                    end
                    // match was one slice ago, so this slice opens the next word.
                    if (detect && !calib_error) begin
                        phase      <= PHASE_BITS'(1);
                        calib_done <= 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        word          = '0;
        word.data     = shift_data;
        word.sync.raw = shift_sync;
    end

endmodule

`default_nettype wire

/* python_rx_pkg.sv */
`default_nettype none

package python_rx_pkg;

    localparam int unsigned NUM_LANES       = 4;
    localparam int unsigned WORD_BITS       = 10;
    localparam int unsigned SLICE_BITS      = 2;
    localparam int unsigned SLICES_PER_WORD = WORD_BITS / SLICE_BITS;

    // training word loaded into REG_PATTERN at reset.
    localparam logic [WORD_BITS-1:0] PATTERN_RESET = 10'h3a6;

    typedef struct packed {
        logic [2:0] code;   // frame/line event type.
        logic [6:0] marker; // fixed 0x2a on a frame/line sync.
    } sync_fields_t;

    typedef union packed {
        logic [WORD_BITS-1:0] raw;
        sync_fields_t         fields;
    } sync_word_u;

    localparam logic [6:0] SYNC_MARKER = 7'h2a;
    localparam logic [2:0] CODE_FS     = 3'd5;
    localparam logic [2:0] CODE_LS     = 3'd1;
    localparam logic [2:0] CODE_LE     = 3'd2;
    localparam logic [2:0] CODE_FE     = 3'd7;

    localparam logic [WORD_BITS-1:0] SYNC_IMAGE = 10'h035;
    localparam logic [WORD_BITS-1:0] SYNC_BLACK = 10'h015;

    typedef struct packed {
        logic [NUM_LANES-1:0][WORD_BITS-1:0] data;
        sync_word_u                          sync;
    } lane_word_t;

    typedef struct packed {
        logic [NUM_LANES-1:0][WORD_BITS-1:0] data;
        logic                                frame_start;
        logic                                line_start;
        logic                                line_end;
        logic                                frame_end;
        logic                                image;
        logic                                black;
    } pixel_beat_t;

    localparam int unsigned REG_CTRL    = 'h00;
    localparam int unsigned REG_PATTERN = 'h04;
    localparam int unsigned REG_STATUS  = 'h08;
    localparam int unsigned REG_FRAMES  = 'h0c;
    localparam int unsigned REG_LINES   = 'h10;

endpackage

`default_nettype wire
